// ==== bench/mem_model.sv ====
/*
 * Memory model
 * Word array answering single-beat write and read addresses with
 * random ready signals. Handshakes seen on the rising edge take
 * effect, and new outputs are driven, on the falling edge.
 */
`timescale 1ns/1ps

module mem_model import parser_pkg::*; #(
    parameter int ADDR_WIDTH = 16,
    parameter int DEPTH      = 2 ** (ADDR_WIDTH - 2)
) (
    input  logic                  aclk,
    input  logic                  resetn,
    input  logic [ADDR_WIDTH-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  data_t                 wdata,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [ADDR_WIDTH-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output data_t                 rdata,
    output logic                  rvalid,
    input  logic                  rready
);

    data_t                 mem [DEPTH];
    integer                seed = 94;
    logic [ADDR_WIDTH-1:0] wq [$];
    logic [ADDR_WIDTH-1:0] rq [$];
    logic                  aw_fire = 1'b0;
    logic                  w_fire = 1'b0;
    logic                  ar_fire = 1'b0;
    logic                  r_fire = 1'b0;
    logic [ADDR_WIDTH-1:0] aw_addr_s;
    logic [ADDR_WIDTH-1:0] ar_addr_s;
    data_t                 w_data_s;

    // Fill pattern built from the whole word address
    initial
    begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = 32'hDEAD0000 ^ (32'(i) * 32'h00010001);
        awready = 1'b0;
        wready  = 1'b0;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
    end

    always @(posedge aclk)
    begin
        aw_fire   = resetn && awvalid && awready;
        w_fire    = resetn && wvalid && wready;
        ar_fire   = resetn && arvalid && arready;
        r_fire    = resetn && rvalid && rready;
        aw_addr_s = awaddr;
        ar_addr_s = araddr;
        w_data_s  = wdata;
    end

    always @(negedge aclk)
    begin
        if (aw_fire)
            wq.push_back(aw_addr_s);
        // Data never comes ahead of its address because wready waits for one
        if (w_fire)
            mem[wq.pop_front() >> 2] = w_data_s;
        if (ar_fire)
            rq.push_back(ar_addr_s);
        if (r_fire)
        begin
            void'(rq.pop_front());
            rvalid = 1'b0;
        end
        if (!resetn)
        begin
            awready = 1'b0;
            wready  = 1'b0;
            arready = 1'b0;
            rvalid  = 1'b0;
        end
        else
        begin
            awready = ($random(seed) & 1) != 0;
            wready  = (($random(seed) & 1) != 0) && (wq.size() > 0);
            arready = ($random(seed) & 1) != 0;
            if (!rvalid && rq.size() > 0 && (($random(seed) & 1) != 0))
            begin
                rvalid = 1'b1;
                rdata  = mem[rq[0] >> 2];
            end
        end
    end

endmodule

// ==== bench/tb_pre_command_parser.sv ====
/*
 * Testbench for the command parser
 * Applies a table of commands, scoreboards the output stream and
 * the memory traffic, and checks memory contents at the end
 */
`timescale 1ns/1ps

module tb_pre_command_parser import parser_pkg::*;;

    localparam int ADDR_W  = 16;
    localparam int TIMEOUT = 2000;
    localparam int NROWS   = 10;

    typedef struct {
        logic [3:0]        op;
        int                len;
        logic [ADDR_W-1:0] addr;
        data_t             base;
    } row_t;

    logic aclk, resetn;
    logic s_cmd_tvalid, s_cmd_tready, s_cmd_tlast;
    data_t s_cmd_tdata;
    logic m_cmd_tvalid, m_cmd_tready, m_cmd_tlast;
    data_t m_cmd_tdata;
    logic [ADDR_W-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, arvalid, arready, rvalid, rready;
    data_t wdata, rdata;

    row_t              rows [NROWS];
    integer            seed = 94;
    int                errors = 0;
    int                timeouts = 0;
    data_t             exp_data [$];
    bit                exp_last [$];
    logic [ADDR_W-1:0] exp_aw [$];
    logic [ADDR_W-1:0] exp_ar [$];
    data_t             exp_w [$];

    pre_command_parser #(.ADDR_WIDTH(ADDR_W)) DUT (.*);

    mem_model #(.ADDR_WIDTH(ADDR_W)) u_mem (.*);

    initial
    begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    always @(negedge aclk)
        m_cmd_tready = resetn && (($random(seed) & 3) != 0);

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp)
        begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
                              input string what);
        if (got !== exp)
        begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_last(input bit got, input bit exp, input string what);
        if (got !== exp)
        begin
            $display("Fail at %0t: %s is %0b, expected %0b", $time, what, got, exp);
            errors++;
        end
    endtask

    // Scoreboards for the output stream and both address channels
    always @(posedge aclk)
    begin
        if (resetn && m_cmd_tvalid && m_cmd_tready)
        begin
            if (exp_data.size() == 0)
            begin
                $display("Output beat %h appeared with none expected at %0t", m_cmd_tdata, $time);
                errors++;
            end
            else
            begin
                check_data(m_cmd_tdata, exp_data.pop_front(), "output data");
                check_last(m_cmd_tlast, exp_last.pop_front(), "output tlast");
            end
        end
        if (resetn && awvalid && awready)
        begin
            if (exp_aw.size() == 0)
            begin
                $display("Write address %h appeared with none expected at %0t", awaddr, $time);
                errors++;
            end
            else
                check_addr(awaddr, exp_aw.pop_front(), "write address");
        end
        if (resetn && wvalid && wready)
        begin
            if (exp_w.size() == 0)
            begin
                $display("Write data %h appeared with none expected at %0t", wdata, $time);
                errors++;
            end
            else
                check_data(wdata, exp_w.pop_front(), "write data");
        end
        if (resetn && arvalid && arready)
        begin
            if (exp_ar.size() == 0)
            begin
                $display("Read address %h appeared with none expected at %0t", araddr, $time);
                errors++;
            end
            else
                check_addr(araddr, exp_ar.pop_front(), "read address");
        end
    end

    task automatic check_quiet(input string phase);
        if (m_cmd_tvalid || awvalid || wvalid || arvalid)
        begin
            $display("A valid output was high %s at %0t", phase, $time);
            errors++;
        end
    endtask

    // Starts and ends on a falling edge
    task automatic send_word(input data_t word, input logic last, input int row);
        int  n;
        bit  accepted;
        n = 0;
        accepted = 1'b0;
        s_cmd_tvalid = 1'b1;
        s_cmd_tdata  = word;
        s_cmd_tlast  = last;
        while (!accepted && n < TIMEOUT)
        begin
            @(posedge aclk);
            accepted = s_cmd_tready;
            n++;
        end
        @(negedge aclk);
        s_cmd_tvalid = 1'b0;
        s_cmd_tlast  = 1'b0;
        if (!accepted)
        begin
            $display("Command row %0d stalled: input word %h was never accepted", row, word);
            timeouts++;
        end
    endtask

    task automatic wait_drain(input int row);
        int n;
        n = 0;
        while ((exp_data.size() + exp_aw.size() + exp_ar.size() + exp_w.size()) != 0
               && n < TIMEOUT)
        begin
            @(negedge aclk);
            n++;
        end
        if ((exp_data.size() + exp_aw.size() + exp_ar.size() + exp_w.size()) != 0)
        begin
            $display("Command row %0d stalled: expected beats never came out", row);
            timeouts++;
        end
    endtask

    task automatic run_row(input row_t r, input int row);
        int beats;
        beats = r.len >> BEAT_SHIFT;
        for (int k = 0; k < beats; k++)
        begin
            if (r.op == OP_STREAM || r.op == OP_LOAD)
            begin
                exp_data.push_back(r.base + data_t'(k));
                exp_last.push_back(k == beats - 1);
            end
            if (r.op == OP_STORE)
            begin
                exp_aw.push_back(r.addr + ADDR_W'(BYTES_PER_BEAT * k));
                exp_w.push_back(r.base + data_t'(k));
            end
            if (r.op == OP_LOAD)
                exp_ar.push_back(r.addr + ADDR_W'(BYTES_PER_BEAT * k));
        end
        send_word({r.op, IMM_W'(r.len)}, 1'b0, row);
        if (r.op == OP_STORE || r.op == OP_LOAD)
            send_word(data_t'(r.addr), 1'b0, row);
        if (r.op == OP_STREAM || r.op == OP_STORE)
        begin
            for (int k = 0; k < beats; k++)
                send_word(r.base + data_t'(k), k == beats - 1, row);
        end
        wait_drain(row);
    endtask

    initial
    begin
        s_cmd_tvalid = 1'b0;
        s_cmd_tlast  = 1'b0;
        s_cmd_tdata  = '0;
        m_cmd_tready = 1'b0;
        resetn       = 1'b0;

        // Unknown opcode 3 and a NOP with a length both act as plain headers
        rows[0] = '{4'd8, 16, 16'h0000, 32'h1000_0000};
        rows[1] = '{4'd0, 0,  16'h0000, 32'h0000_0000};
        rows[2] = '{4'd5, 20, 16'h0100, 32'h2000_0000};
        rows[3] = '{4'd6, 20, 16'h0100, 32'h2000_0000};
        rows[4] = '{4'd8, 4,  16'h0000, 32'h3000_0000};
        rows[5] = '{4'd3, 8,  16'h0000, 32'h0000_0000};
        rows[6] = '{4'd5, 32, 16'h0240, 32'h4000_0000};
        rows[7] = '{4'd0, 12, 16'h0000, 32'h0000_0000};
        rows[8] = '{4'd6, 32, 16'h0240, 32'h4000_0000};
        rows[9] = '{4'd8, 40, 16'h0000, 32'h5000_0000};

        for (int i = 0; i < 8; i++)
        begin
            @(posedge aclk);
            check_quiet("during reset");
        end
        @(negedge aclk);
        resetn = 1'b1;
        for (int i = 0; i < 2; i++)
        begin
            @(posedge aclk);
            check_quiet("just after reset");
        end
        @(posedge aclk);
        if (!s_cmd_tready)
        begin
            $display("s_cmd_tready was still low three cycles after reset");
            errors++;
        end
        @(negedge aclk);

        for (int i = 0; i < NROWS && timeouts == 0; i++)
            run_row(rows[i], i);

        // Stored words must still be in memory at the end
        for (int i = 0; i < NROWS; i++)
        begin
            if (rows[i].op == OP_STORE)
            begin
                for (int k = 0; k < (rows[i].len >> BEAT_SHIFT); k++)
                    check_data(u_mem.mem[int'(rows[i].addr >> 2) + k],
                               rows[i].base + data_t'(k), "memory word");
            end
        end

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the command parser testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_pre_command_parser --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== verilog.f ====
verilog/parser_pkg.sv
verilog/cmd_decoder.sv
verilog/beat_mover.sv
verilog/addr_gen.sv
verilog/channel_mux.sv
verilog/pre_command_parser.sv
bench/mem_model.sv
bench/tb_pre_command_parser.sv

// ==== verilog/addr_gen.sv ====
/*
 * Address generator
 * Issues one single-beat address per beat on the write or the read
 * address channel, stepping one word from the start address
 */
`timescale 1ns/1ps

module addr_gen import parser_pkg::*; #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                  aclk,
    input  logic                  resetn,
    input  logic                  start,
    input  logic [IMM_W-1:0]      beat_count,
    input  logic [ADDR_WIDTH-1:0] start_addr,
    input  logic                  write_not_read,
    output logic [ADDR_WIDTH-1:0] awaddr,
    output logic                  awvalid,
    input  logic                  awready,
    output logic [ADDR_WIDTH-1:0] araddr,
    output logic                  arvalid,
    input  logic                  arready,
    output logic                  done
);

    logic [ADDR_WIDTH-1:0] addr;
    logic [IMM_W-1:0]      remaining;
    logic                  is_write;
    logic                  addr_valid;
    logic                  accepted;

    assign awaddr   = addr;
    assign araddr   = addr;
    assign awvalid  = addr_valid && is_write;
    assign arvalid  = addr_valid && !is_write;
    assign accepted = (awvalid && awready) || (arvalid && arready);

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            addr_valid <= 1'b0;
            remaining  <= '0;
            is_write   <= 1'b0;
            done       <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                addr_valid <= (beat_count != '0);
                remaining  <= beat_count;
                is_write   <= write_not_read;
            end
            else if (accepted)
            begin
                remaining <= remaining - IMM_W'(1);
                // Last address of the command went out
                if (remaining == IMM_W'(1))
                begin
                    addr_valid <= 1'b0;
                    done       <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (start)
            addr <= start_addr;
        else if (accepted)
            addr <= addr + ADDR_WIDTH'(BYTES_PER_BEAT);
    end

    // An offered address holds on its channel until the slave takes it
    assert property (@(posedge aclk) disable iff (!resetn)
        addr_valid && !accepted |=> addr_valid && $stable(addr) && $stable(is_write));

endmodule

// ==== verilog/beat_mover.sv ====
/*
 * Beat mover
 * Counts down the beats of one command and copies them from the
 * selected source to the selected sink. A one-entry skid buffer
 * catches the beat in flight when the sink stalls.
 */
`timescale 1ns/1ps

module beat_mover import parser_pkg::*; (
    input  logic             aclk,
    input  logic             resetn,
    input  logic             start,
    input  logic [IMM_W-1:0] beat_count,
    input  logic             src_valid,
    input  data_t            src_data,
    input  logic             src_last,
    output logic             src_ready,
    output logic             dst_valid,
    output data_t            dst_data,
    output logic             dst_last,
    input  logic             dst_ready,
    output logic             done
);

    logic [IMM_W-1:0] remaining;
    logic             skid_valid;
    data_t            skid_data;
    logic             skid_last;
    logic             take;
    logic             out_free;
    logic             in_last;

    // Source is held off once the skid entry is occupied
    assign src_ready = (remaining != '0) && !skid_valid;
    assign take      = src_valid && src_ready;
    assign out_free  = !dst_valid || dst_ready;
    assign in_last   = (remaining == IMM_W'(1));

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            remaining  <= '0;
            skid_valid <= 1'b0;
            dst_valid  <= 1'b0;
            done       <= 1'b0;
        end
        else
        begin
            done <= dst_valid && dst_ready && dst_last;

            if (start)
                remaining <= beat_count;
            else if (take)
                remaining <= remaining - IMM_W'(1);

            if (out_free)
            begin
                if (skid_valid)
                begin
                    dst_valid  <= 1'b1;
                    skid_valid <= 1'b0;
                end
                else
                    dst_valid <= take;
            end
            else if (take)
                skid_valid <= 1'b1;
        end
    end

    // Payload path
    always_ff @(posedge aclk)
    begin
        if (out_free)
        begin
            if (skid_valid)
            begin
                dst_data <= skid_data;
                dst_last <= skid_last;
            end
            else if (take)
            begin
                dst_data <= src_data;
                dst_last <= in_last;
            end
        end
        else if (take)
        begin
            skid_data <= src_data;
            skid_last <= in_last;
        end
    end

    // A stalled beat stays put until the sink takes it
    assert property (@(posedge aclk) disable iff (!resetn)
        dst_valid && !dst_ready |=> dst_valid && $stable(dst_data) && $stable(dst_last));

    // A source marked last lines up with the end of the count
    assert property (@(posedge aclk) disable iff (!resetn)
        take && src_last |-> in_last);

endmodule

// ==== verilog/channel_mux.sv ====
/*
 * Channel mux
 * Routes the external streams to the decoder or the beat mover
 * depending on which route holds the grant. Unselected ports see
 * valid and ready low and zero data.
 */
`timescale 1ns/1ps

module channel_mux import parser_pkg::*; (
    input  route_e    route,
    input  logic      s_cmd_tvalid,
    output logic      s_cmd_tready,
    input  logic      s_cmd_tlast,
    input  data_t     s_cmd_tdata,
    output logic      m_cmd_tvalid,
    input  logic      m_cmd_tready,
    output logic      m_cmd_tlast,
    output data_t     m_cmd_tdata,
    output data_t     wdata,
    output logic      wvalid,
    input  logic      wready,
    input  data_t     rdata,
    input  logic      rvalid,
    output logic      rready,
    output logic      in_valid,
    output cmd_word_u in_data,
    input  logic      in_ready,
    output logic      src_valid,
    output data_t     src_data,
    output logic      src_last,
    input  logic      src_ready,
    input  logic      dst_valid,
    input  data_t     dst_data,
    input  logic      dst_last,
    output logic      dst_ready
);

    always_comb
    begin
        s_cmd_tready = 1'b0;
        m_cmd_tvalid = 1'b0;
        m_cmd_tlast  = 1'b0;
        m_cmd_tdata  = '0;
        wdata        = '0;
        wvalid       = 1'b0;
        rready       = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        src_valid    = 1'b0;
        src_data     = '0;
        src_last     = 1'b0;
        dst_ready    = 1'b0;

        // Source side
        case (route)
            ROUTE_CMD:
            begin
                in_valid     = s_cmd_tvalid;
                in_data.raw  = s_cmd_tdata;
                s_cmd_tready = in_ready;
            end
            ROUTE_STREAM, ROUTE_STORE:
            begin
                src_valid    = s_cmd_tvalid;
                src_data     = s_cmd_tdata;
                src_last     = s_cmd_tlast;
                s_cmd_tready = src_ready;
            end
            ROUTE_LOAD:
            begin
                src_valid = rvalid;
                src_data  = rdata;
                rready    = src_ready;
            end
            default:
            begin
            end
        endcase

        // Sink side
        case (route)
            ROUTE_STREAM, ROUTE_LOAD:
            begin
                m_cmd_tvalid = dst_valid;
                m_cmd_tdata  = dst_data;
                m_cmd_tlast  = dst_last;
                dst_ready    = m_cmd_tready;
            end
            ROUTE_STORE:
            begin
                wvalid    = dst_valid;
                wdata     = dst_data;
                dst_ready = wready;
            end
            default:
            begin
            end
        endcase
    end

endmodule

// ==== verilog/cmd_decoder.sv ====
/*
 * Command decoder
 * Reads header and address words from the input stream and grants
 * the shared streams to one route per command. Waits for the beat
 * mover and the address generator before taking the next header.
 */
`timescale 1ns/1ps

module cmd_decoder import parser_pkg::*; #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                  aclk,
    input  logic                  resetn,
    input  logic                  in_valid,
    input  cmd_word_u             in_data,
    output logic                  in_ready,
    input  logic                  mover_done,
    input  logic                  addr_done,
    output route_e                route,
    output logic [IMM_W-1:0]      beat_count,
    output logic [ADDR_WIDTH-1:0] start_addr,
    output logic                  start
);

    typedef enum logic [1:0] {IDLE, HEADER, ADDRESS, BUSY} state_e;

    state_e           state;
    route_e           pending;
    logic             mover_fin;
    logic             addr_fin;
    logic             accept;
    logic [IMM_W-1:0] hdr_beats;

    assign in_ready  = (state == HEADER) || (state == ADDRESS);
    assign accept    = in_valid && in_ready;
    assign hdr_beats = in_data.hdr.len >> BEAT_SHIFT;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state     <= IDLE;
            route     <= ROUTE_NONE;
            pending   <= ROUTE_NONE;
            start     <= 1'b0;
            mover_fin <= 1'b0;
            addr_fin  <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            case (state)
                IDLE:
                begin
                    route <= ROUTE_CMD;
                    state <= HEADER;
                end
                HEADER:
                begin
                    if (accept)
                    begin
                        beat_count <= hdr_beats;
                        case (in_data.hdr.op)
                            OP_STREAM:
                            begin
                                // Zero-length stream carries nothing
                                if (hdr_beats != '0)
                                begin
                                    route     <= ROUTE_STREAM;
                                    start     <= 1'b1;
                                    mover_fin <= 1'b0;
                                    addr_fin  <= 1'b1;
                                    state     <= BUSY;
                                end
                                else
                                    state <= IDLE;
                            end
                            OP_STORE:
                            begin
                                pending <= ROUTE_STORE;
                                state   <= ADDRESS;
                            end
                            OP_LOAD:
                            begin
                                pending <= ROUTE_LOAD;
                                state   <= ADDRESS;
                            end
                            default:
                                state <= IDLE;
                        endcase
                    end
                end
                ADDRESS:
                begin
                    if (accept)
                    begin
                        start_addr <= in_data.raw[ADDR_WIDTH-1:0];
                        if (beat_count != '0)
                        begin
                            route     <= pending;
                            start     <= 1'b1;
                            mover_fin <= 1'b0;
                            addr_fin  <= 1'b0;
                            state     <= BUSY;
                        end
                        else
                            state <= IDLE;
                    end
                end
                BUSY:
                begin
                    mover_fin <= mover_fin || mover_done;
                    addr_fin  <= addr_fin || addr_done;
                    if ((mover_fin || mover_done) && (addr_fin || addr_done))
                    begin
                        route <= ROUTE_NONE;
                        state <= IDLE;
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Engines report done only while a command runs
    assert property (@(posedge aclk) disable iff (!resetn)
        (mover_done || addr_done) |-> (state == BUSY));

endmodule

// ==== verilog/parser_pkg.sv ====
/*
 * Command parser package
 * Shared beat constants, opcode and route encodings, and the
 * command word type that the front end decodes two ways
 */
package parser_pkg;

    localparam int DATA_W         = 32;
    localparam int BYTES_PER_BEAT = 4;
    localparam int BEAT_SHIFT     = 2;
    localparam int IMM_W          = 28;

    typedef logic [DATA_W-1:0] data_t;

    // Opcodes live in the top nibble of a header word
    typedef enum logic [3:0]
    {
        OP_NOP    = 4'd0,
        OP_STORE  = 4'd5,
        OP_LOAD   = 4'd6,
        OP_STREAM = 4'd8
    } op_e;

    // Which path currently owns the shared streams
    typedef enum logic [2:0]
    {
        ROUTE_CMD    = 3'd0,
        ROUTE_STREAM = 3'd1,
        ROUTE_STORE  = 3'd2,
        ROUTE_LOAD   = 3'd3,
        ROUTE_NONE   = 3'd4
    } route_e;

    typedef struct packed
    {
        op_e              op;
        logic [IMM_W-1:0] len;
    } cmd_hdr_t;

    // Header view for commands, raw view for address and data words
    typedef union packed
    {
        cmd_hdr_t hdr;
        data_t    raw;
    } cmd_word_u;

endpackage

// ==== verilog/pre_command_parser.sv ====
/*
 * Pre command parser
 * Command stream front end. Splits a 32-bit command stream into
 * stream copies, memory stores and memory loads.
 */
`timescale 1ns/1ps

module pre_command_parser import parser_pkg::*; #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                  aclk,
    input  logic                  resetn,
    input  logic                  s_cmd_tvalid,
    output logic                  s_cmd_tready,
    input  logic                  s_cmd_tlast,
    input  data_t                 s_cmd_tdata,
    output logic                  m_cmd_tvalid,
    input  logic                  m_cmd_tready,
    output logic                  m_cmd_tlast,
    output data_t                 m_cmd_tdata,
    output logic [ADDR_WIDTH-1:0] awaddr,
    output logic                  awvalid,
    input  logic                  awready,
    output data_t                 wdata,
    output logic                  wvalid,
    input  logic                  wready,
    output logic [ADDR_WIDTH-1:0] araddr,
    output logic                  arvalid,
    input  logic                  arready,
    input  data_t                 rdata,
    input  logic                  rvalid,
    output logic                  rready
);

    route_e                route;
    logic [IMM_W-1:0]      beat_count;
    logic [ADDR_WIDTH-1:0] start_addr;
    logic                  start;
    logic                  mover_done;
    logic                  addr_done;
    logic                  in_valid;
    cmd_word_u             in_data;
    logic                  in_ready;
    logic                  src_valid;
    data_t                 src_data;
    logic                  src_last;
    logic                  src_ready;
    logic                  dst_valid;
    data_t                 dst_data;
    logic                  dst_last;
    logic                  dst_ready;
    logic                  write_not_read;
    logic                  addr_start;

    // Only memory routes need addresses
    assign write_not_read = (route == ROUTE_STORE);
    assign addr_start     = start && ((route == ROUTE_STORE) || (route == ROUTE_LOAD));

    cmd_decoder #(.ADDR_WIDTH(ADDR_WIDTH)) u_decoder (
        .aclk(aclk), .resetn(resetn),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .mover_done(mover_done), .addr_done(addr_done),
        .route(route), .beat_count(beat_count), .start_addr(start_addr), .start(start)
    );

    beat_mover u_mover (
        .aclk(aclk), .resetn(resetn), .start(start), .beat_count(beat_count),
        .src_valid(src_valid), .src_data(src_data), .src_last(src_last),
        .src_ready(src_ready),
        .dst_valid(dst_valid), .dst_data(dst_data), .dst_last(dst_last),
        .dst_ready(dst_ready), .done(mover_done)
    );

    addr_gen #(.ADDR_WIDTH(ADDR_WIDTH)) u_addr_gen (
        .aclk(aclk), .resetn(resetn), .start(addr_start), .beat_count(beat_count),
        .start_addr(start_addr), .write_not_read(write_not_read),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready), .done(addr_done)
    );

    channel_mux u_mux (
        .route(route),
        .s_cmd_tvalid(s_cmd_tvalid), .s_cmd_tready(s_cmd_tready),
        .s_cmd_tlast(s_cmd_tlast), .s_cmd_tdata(s_cmd_tdata),
        .m_cmd_tvalid(m_cmd_tvalid), .m_cmd_tready(m_cmd_tready),
        .m_cmd_tlast(m_cmd_tlast), .m_cmd_tdata(m_cmd_tdata),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .src_valid(src_valid), .src_data(src_data), .src_last(src_last),
        .src_ready(src_ready),
        .dst_valid(dst_valid), .dst_data(dst_data), .dst_last(dst_last),
        .dst_ready(dst_ready)
    );

endmodule
